// ==== source/soc_bus_pkg.sv ====
// Shared bus package with widths, response codes, address map and memory word types
package soc_bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

	// Window sizes are in address bits
	localparam addr_t BOOT_BASE = 32'h0201_0000;
	localparam int unsigned BOOT_WINDOW = 16;
	localparam addr_t PALETTE_BASE = 32'h0200_2000;
	localparam int unsigned PALETTE_WINDOW = 13;
	localparam addr_t COUNTER_BASE = 32'h0200_0300;
	localparam int unsigned COUNTER_WINDOW = 8;

	localparam int unsigned SUB_COUNT = 3;

	// No-match code sits just past the last real subordinate
	typedef enum logic [1:0] {
		SUB_BOOT,
		SUB_PALETTE,
		SUB_COUNTER,
		SUB_NONE = 2'(SUB_COUNT)
	} sub_sel_t;

	typedef logic [31:0] boot_word_t;
	typedef logic [15:0] colour_t;

endpackage

// ==== source/system_counter.sv ====
// Free-running cycle counter as a read-only AXI4-Lite subordinate
`timescale 1ns/1ns

module system_counter import soc_bus_pkg::*; (
	input logic clk_50mhz,
	input logic resetn,

	input addr_t awaddr,
	input data_t wdata,
	input strb_t wstrb,
	input logic awvalid,
	output logic awready,
	output resp_t bresp,
	output logic bvalid,
	input logic bready,

	input addr_t araddr,
	input logic arvalid,
	output logic arready,
	output data_t rdata,
	output resp_t rresp,
	output logic rvalid,
	input logic rready
);

	logic [31:0] count;

	assign awready = ~bvalid;
	assign arready = ~rvalid;
	// Writes are refused, address and data ignored
	assign bresp = RESP_SLVERR;
	assign rresp = RESP_OKAY;

	always_ff @(posedge clk_50mhz) begin
		if (arvalid && arready)
			rdata <= count;
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			count <= 32'h0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			count <= count + 32'd1;
			if (awvalid && awready)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (arvalid && arready)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

endmodule

// ==== source/axil_ram.sv ====
// AXI4-Lite memory of typed words with an independent registered lookup read port
`timescale 1ns/1ns

module axil_ram import soc_bus_pkg::*; #(
	parameter type word_t = logic [31:0],
	parameter int unsigned DEPTH = 1024,
	localparam int unsigned IDX_W = $clog2(DEPTH)
) (
	input logic clk_50mhz,
	input logic resetn,

	input addr_t awaddr,
	input data_t wdata,
	input strb_t wstrb,
	input logic awvalid,
	output logic awready,
	output resp_t bresp,
	output logic bvalid,
	input logic bready,

	input addr_t araddr,
	input logic arvalid,
	output logic arready,
	output data_t rdata,
	output resp_t rresp,
	output logic rvalid,
	input logic rready,

	input logic [IDX_W-1:0] lookup_addr,
	output word_t lookup_data
);

	localparam int unsigned WORD_BYTES = ($bits(word_t) + 7) / 8;
	// Byte lanes that exist both on the bus and in the word
	localparam int unsigned LANES = (WORD_BYTES < $bits(strb_t)) ? WORD_BYTES : $bits(strb_t);

	word_t mem [DEPTH];

	logic [IDX_W-1:0] widx;
	logic [IDX_W-1:0] ridx;
	logic aw_fire;
	logic ar_fire;

	// Word index from byte address, wraps at DEPTH
	assign widx = awaddr[IDX_W+1:2];
	assign ridx = araddr[IDX_W+1:2];

	assign awready = ~bvalid;
	assign arready = ~rvalid;
	assign aw_fire = awvalid & awready;
	assign ar_fire = arvalid & arready;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	always_ff @(posedge clk_50mhz) begin
		if (aw_fire) begin
			for (int b = 0; b < LANES; b++) begin
				if (wstrb[b])
					mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
		// Zero-extended to bus width
		if (ar_fire)
			rdata <= data_t'(mem[ridx]);
	end

	// Display lookup, one cycle latency
	always_ff @(posedge clk_50mhz) begin
		lookup_data <= mem[lookup_addr];
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (aw_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (ar_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

endmodule

// ==== source/addr_decoder.sv ====
// Address decoder steering the shared bus to one subordinate, answering unmapped addresses
`timescale 1ns/1ns

module addr_decoder import soc_bus_pkg::*; (
	input logic clk_50mhz,
	input logic resetn,

	input addr_t bus_awaddr, bus_araddr,
	input data_t bus_wdata,
	input strb_t bus_wstrb,
	input logic bus_awvalid, bus_bready, bus_arvalid, bus_rready,
	output logic bus_awready, bus_bvalid, bus_arready, bus_rvalid,
	output resp_t bus_bresp, bus_rresp,
	output data_t bus_rdata,

	output addr_t boot_awaddr, boot_araddr,
	output data_t boot_wdata,
	output strb_t boot_wstrb,
	output logic boot_awvalid, boot_bready, boot_arvalid, boot_rready,
	input logic boot_awready, boot_bvalid, boot_arready, boot_rvalid,
	input resp_t boot_bresp, boot_rresp,
	input data_t boot_rdata,

	output addr_t pal_awaddr, pal_araddr,
	output data_t pal_wdata,
	output strb_t pal_wstrb,
	output logic pal_awvalid, pal_bready, pal_arvalid, pal_rready,
	input logic pal_awready, pal_bvalid, pal_arready, pal_rvalid,
	input resp_t pal_bresp, pal_rresp,
	input data_t pal_rdata,

	output addr_t cnt_awaddr, cnt_araddr,
	output data_t cnt_wdata,
	output strb_t cnt_wstrb,
	output logic cnt_awvalid, cnt_bready, cnt_arvalid, cnt_rready,
	input logic cnt_awready, cnt_bvalid, cnt_arready, cnt_rvalid,
	input resp_t cnt_bresp, cnt_rresp,
	input data_t cnt_rdata
);

	sub_sel_t req_sel;
	sub_sel_t resp_sel;
	addr_t req_addr;
	logic err_bvalid, err_rvalid;
	logic aw_fire, ar_fire;

	function automatic logic in_window(addr_t addr, addr_t base, int unsigned bits);
		return (addr >> bits) == (base >> bits);
	endfunction

	// Arbiter never raises both valids at once
	assign req_addr = bus_awvalid ? bus_awaddr : bus_araddr;

	always_comb begin
		if (in_window(req_addr, BOOT_BASE, BOOT_WINDOW))
			req_sel = SUB_BOOT;
		else if (in_window(req_addr, PALETTE_BASE, PALETTE_WINDOW))
			req_sel = SUB_PALETTE;
		else if (in_window(req_addr, COUNTER_BASE, COUNTER_WINDOW))
			req_sel = SUB_COUNTER;
		else
			req_sel = SUB_NONE;
	end

	assign {boot_awaddr, pal_awaddr, cnt_awaddr} = {3{bus_awaddr}};
	assign {boot_araddr, pal_araddr, cnt_araddr} = {3{bus_araddr}};
	assign {boot_wdata, pal_wdata, cnt_wdata} = {3{bus_wdata}};
	assign {boot_wstrb, pal_wstrb, cnt_wstrb} = {3{bus_wstrb}};

	assign boot_awvalid = bus_awvalid & (req_sel == SUB_BOOT);
	assign pal_awvalid = bus_awvalid & (req_sel == SUB_PALETTE);
	assign cnt_awvalid = bus_awvalid & (req_sel == SUB_COUNTER);
	assign boot_arvalid = bus_arvalid & (req_sel == SUB_BOOT);
	assign pal_arvalid = bus_arvalid & (req_sel == SUB_PALETTE);
	assign cnt_arvalid = bus_arvalid & (req_sel == SUB_COUNTER);

	// Response side follows the subordinate that accepted
	assign boot_bready = bus_bready & (resp_sel == SUB_BOOT);
	assign pal_bready = bus_bready & (resp_sel == SUB_PALETTE);
	assign cnt_bready = bus_bready & (resp_sel == SUB_COUNTER);
	assign boot_rready = bus_rready & (resp_sel == SUB_BOOT);
	assign pal_rready = bus_rready & (resp_sel == SUB_PALETTE);
	assign cnt_rready = bus_rready & (resp_sel == SUB_COUNTER);

	always_comb begin
		case (req_sel)
			SUB_BOOT: {bus_awready, bus_arready} = {boot_awready, boot_arready};
			SUB_PALETTE: {bus_awready, bus_arready} = {pal_awready, pal_arready};
			SUB_COUNTER: {bus_awready, bus_arready} = {cnt_awready, cnt_arready};
			default: {bus_awready, bus_arready} = {2{~(err_bvalid | err_rvalid)}};
		endcase
		case (resp_sel)
			SUB_BOOT: {bus_bvalid, bus_bresp, bus_rvalid, bus_rresp, bus_rdata} =
				{boot_bvalid, boot_bresp, boot_rvalid, boot_rresp, boot_rdata};
			SUB_PALETTE: {bus_bvalid, bus_bresp, bus_rvalid, bus_rresp, bus_rdata} =
				{pal_bvalid, pal_bresp, pal_rvalid, pal_rresp, pal_rdata};
			SUB_COUNTER: {bus_bvalid, bus_bresp, bus_rvalid, bus_rresp, bus_rdata} =
				{cnt_bvalid, cnt_bresp, cnt_rvalid, cnt_rresp, cnt_rdata};
			default: {bus_bvalid, bus_bresp, bus_rvalid, bus_rresp, bus_rdata} =
				{err_bvalid, RESP_DECERR, err_rvalid, RESP_DECERR, 32'h0};
		endcase
	end

	assign aw_fire = bus_awvalid & bus_awready;
	assign ar_fire = bus_arvalid & bus_arready;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			resp_sel <= SUB_NONE;
			err_bvalid <= 1'b0;
			err_rvalid <= 1'b0;
		end else begin
			if (aw_fire | ar_fire)
				resp_sel <= req_sel;
			// Unmapped access, answered locally
			if (aw_fire && req_sel == SUB_NONE)
				err_bvalid <= 1'b1;
			else if (bus_bready)
				err_bvalid <= 1'b0;
			if (ar_fire && req_sel == SUB_NONE)
				err_rvalid <= 1'b1;
			else if (bus_rready)
				err_rvalid <= 1'b0;
		end
	end

endmodule

// ==== source/bus_arbiter.sv ====
// Round-robin arbiter granting the shared bus to one manager per transaction
`timescale 1ns/1ns

module bus_arbiter import soc_bus_pkg::*; (
	input logic clk_50mhz,
	input logic resetn,

	input addr_t cpu_awaddr, cpu_araddr,
	input data_t cpu_wdata,
	input strb_t cpu_wstrb,
	input logic cpu_awvalid, cpu_wvalid, cpu_bready, cpu_arvalid, cpu_rready,
	output logic cpu_awready, cpu_wready, cpu_bvalid, cpu_arready, cpu_rvalid,
	output resp_t cpu_bresp, cpu_rresp,
	output data_t cpu_rdata,

	input addr_t gfx_awaddr, gfx_araddr,
	input data_t gfx_wdata,
	input strb_t gfx_wstrb,
	input logic gfx_awvalid, gfx_wvalid, gfx_bready, gfx_arvalid, gfx_rready,
	output logic gfx_awready, gfx_wready, gfx_bvalid, gfx_arready, gfx_rvalid,
	output resp_t gfx_bresp, gfx_rresp,
	output data_t gfx_rdata,

	output addr_t bus_awaddr, bus_araddr,
	output data_t bus_wdata,
	output strb_t bus_wstrb,
	output logic bus_awvalid, bus_bready, bus_arvalid, bus_rready,
	input logic bus_awready, bus_bvalid, bus_arready, bus_rvalid,
	input resp_t bus_bresp, bus_rresp,
	input data_t bus_rdata
);

	// One-hot grant, bit 0 is cpu and bit 1 is gfx
	logic [1:0] grant;
	logic last_id;
	logic grant_write;
	logic txn_open;
	logic cpu_wr_req, gfx_wr_req;
	logic cpu_req, gfx_req;
	logic next_id;
	logic issue;
	logic aw_ok, ar_ok;
	logic done;

	assign cpu_wr_req = cpu_awvalid & cpu_wvalid;
	assign gfx_wr_req = gfx_awvalid & gfx_wvalid;
	assign cpu_req = cpu_wr_req | cpu_arvalid;
	assign gfx_req = gfx_wr_req | gfx_arvalid;

	// Tie goes to whoever did not win last
	assign next_id = (cpu_req & gfx_req) ? ~last_id : gfx_req;

	assign issue = (|grant) & ~txn_open;
	assign done = (bus_bvalid & bus_bready) | (bus_rvalid & bus_rready);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			grant <= 2'b00;
			last_id <= 1'b1;
			grant_write <= 1'b0;
			txn_open <= 1'b0;
		end else if (grant == 2'b00) begin
			if (cpu_req | gfx_req) begin
				grant <= next_id ? 2'b10 : 2'b01;
				last_id <= next_id;
				// Write wins over read from the same manager
				grant_write <= next_id ? gfx_wr_req : cpu_wr_req;
			end
		end else begin
			if ((bus_awvalid & bus_awready) | (bus_arvalid & bus_arready))
				txn_open <= 1'b1;
			if (done) begin
				grant <= 2'b00;
				txn_open <= 1'b0;
			end
		end
	end

	assign bus_awaddr = grant[1] ? gfx_awaddr : cpu_awaddr;
	assign bus_wdata = grant[1] ? gfx_wdata : cpu_wdata;
	assign bus_wstrb = grant[1] ? gfx_wstrb : cpu_wstrb;
	assign bus_araddr = grant[1] ? gfx_araddr : cpu_araddr;

	assign bus_awvalid = issue & grant_write & (grant[1] ? gfx_wr_req : cpu_wr_req);
	assign bus_arvalid = issue & ~grant_write & (grant[1] ? gfx_arvalid : cpu_arvalid);
	assign bus_bready = (grant[0] & cpu_bready) | (grant[1] & gfx_bready);
	assign bus_rready = (grant[0] & cpu_rready) | (grant[1] & gfx_rready);

	assign aw_ok = issue & grant_write & bus_awready;
	assign ar_ok = issue & ~grant_write & bus_arready;

	// Loser sees every ready and valid held low
	assign cpu_awready = grant[0] & aw_ok;
	assign cpu_wready = grant[0] & aw_ok;
	assign cpu_arready = grant[0] & ar_ok;
	assign cpu_bvalid = grant[0] & bus_bvalid;
	assign cpu_rvalid = grant[0] & bus_rvalid;
	assign cpu_bresp = bus_bresp;
	assign cpu_rresp = bus_rresp;
	assign cpu_rdata = bus_rdata;

	assign gfx_awready = grant[1] & aw_ok;
	assign gfx_wready = grant[1] & aw_ok;
	assign gfx_arready = grant[1] & ar_ok;
	assign gfx_bvalid = grant[1] & bus_bvalid;
	assign gfx_rvalid = grant[1] & bus_rvalid;
	assign gfx_bresp = bus_bresp;
	assign gfx_rresp = bus_rresp;
	assign gfx_rdata = bus_rdata;

endmodule

// ==== source/soc_bus_top.sv ====
// System bus top joining the arbiter, address decoder and the three subordinates
`timescale 1ns/1ns

module soc_bus_top import soc_bus_pkg::*; #(
	parameter int unsigned BOOT_DEPTH = 1024,
	parameter int unsigned PALETTE_DEPTH = 256
) (
	input logic clk_50mhz,
	input logic resetn,

	input addr_t cpu_awaddr, cpu_araddr,
	input data_t cpu_wdata,
	input strb_t cpu_wstrb,
	input logic cpu_awvalid, cpu_wvalid, cpu_bready, cpu_arvalid, cpu_rready,
	output logic cpu_awready, cpu_wready, cpu_bvalid, cpu_arready, cpu_rvalid,
	output resp_t cpu_bresp, cpu_rresp,
	output data_t cpu_rdata,

	input addr_t gfx_awaddr, gfx_araddr,
	input data_t gfx_wdata,
	input strb_t gfx_wstrb,
	input logic gfx_awvalid, gfx_wvalid, gfx_bready, gfx_arvalid, gfx_rready,
	output logic gfx_awready, gfx_wready, gfx_bvalid, gfx_arready, gfx_rvalid,
	output resp_t gfx_bresp, gfx_rresp,
	output data_t gfx_rdata,

	input logic [7:0] palette_addr,
	output colour_t palette_colour
);

	// Shared manager-side bus
	addr_t bus_awaddr, bus_araddr;
	data_t bus_wdata, bus_rdata;
	strb_t bus_wstrb;
	resp_t bus_bresp, bus_rresp;
	logic bus_awvalid, bus_awready, bus_bvalid, bus_bready;
	logic bus_arvalid, bus_arready, bus_rvalid, bus_rready;

	addr_t boot_awaddr, boot_araddr;
	data_t boot_wdata, boot_rdata;
	strb_t boot_wstrb;
	resp_t boot_bresp, boot_rresp;
	logic boot_awvalid, boot_awready, boot_bvalid, boot_bready;
	logic boot_arvalid, boot_arready, boot_rvalid, boot_rready;

	addr_t pal_awaddr, pal_araddr;
	data_t pal_wdata, pal_rdata;
	strb_t pal_wstrb;
	resp_t pal_bresp, pal_rresp;
	logic pal_awvalid, pal_awready, pal_bvalid, pal_bready;
	logic pal_arvalid, pal_arready, pal_rvalid, pal_rready;

	addr_t cnt_awaddr, cnt_araddr;
	data_t cnt_wdata, cnt_rdata;
	strb_t cnt_wstrb;
	resp_t cnt_bresp, cnt_rresp;
	logic cnt_awvalid, cnt_awready, cnt_bvalid, cnt_bready;
	logic cnt_arvalid, cnt_arready, cnt_rvalid, cnt_rready;

	bus_arbiter i_arbiter (.*);

	addr_decoder i_decoder (.*);

	axil_ram #(
		.word_t(boot_word_t),
		.DEPTH(BOOT_DEPTH)
	) i_boot_ram (
		.clk_50mhz,
		.resetn,
		.awaddr(boot_awaddr),
		.wdata(boot_wdata),
		.wstrb(boot_wstrb),
		.awvalid(boot_awvalid),
		.awready(boot_awready),
		.bresp(boot_bresp),
		.bvalid(boot_bvalid),
		.bready(boot_bready),
		.araddr(boot_araddr),
		.arvalid(boot_arvalid),
		.arready(boot_arready),
		.rdata(boot_rdata),
		.rresp(boot_rresp),
		.rvalid(boot_rvalid),
		.rready(boot_rready),
		// No display-side reader on boot memory
		.lookup_addr('0),
		.lookup_data()
	);

	axil_ram #(
		.word_t(colour_t),
		.DEPTH(PALETTE_DEPTH)
	) i_palette_ram (
		.clk_50mhz,
		.resetn,
		.awaddr(pal_awaddr),
		.wdata(pal_wdata),
		.wstrb(pal_wstrb),
		.awvalid(pal_awvalid),
		.awready(pal_awready),
		.bresp(pal_bresp),
		.bvalid(pal_bvalid),
		.bready(pal_bready),
		.araddr(pal_araddr),
		.arvalid(pal_arvalid),
		.arready(pal_arready),
		.rdata(pal_rdata),
		.rresp(pal_rresp),
		.rvalid(pal_rvalid),
		.rready(pal_rready),
		.lookup_addr(palette_addr),
		.lookup_data(palette_colour)
	);

	system_counter i_counter (
		.clk_50mhz,
		.resetn,
		.awaddr(cnt_awaddr),
		.wdata(cnt_wdata),
		.wstrb(cnt_wstrb),
		.awvalid(cnt_awvalid),
		.awready(cnt_awready),
		.bresp(cnt_bresp),
		.bvalid(cnt_bvalid),
		.bready(cnt_bready),
		.araddr(cnt_araddr),
		.arvalid(cnt_arvalid),
		.arready(cnt_arready),
		.rdata(cnt_rdata),
		.rresp(cnt_rresp),
		.rvalid(cnt_rvalid),
		.rready(cnt_rready)
	);

endmodule

// ==== tests/soc_bus_props.sv ====
// Bound checks on the arbiter grant and the shared bus handshakes
`timescale 1ns/1ns

module soc_bus_props import soc_bus_pkg::*; (
	input logic clk_50mhz,
	input logic resetn,
	input logic [1:0] grant,
	input logic txn_open,
	input data_t bus_rdata,
	input logic bus_awvalid, bus_arvalid,
	input logic bus_bvalid, bus_bready, bus_rvalid, bus_rready,
	input resp_t bus_bresp, bus_rresp
);

	logic done;

	assign done = (bus_bvalid & bus_bready) | (bus_rvalid & bus_rready);

	a_one_grant: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$onehot0(grant)) else $error("both managers granted at once");

	a_grant_held: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		txn_open && !done |=> $stable(grant)) else $error("grant moved during open transaction");

	a_b_stable: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		bus_bvalid && !bus_bready |=> bus_bvalid && $stable(bus_bresp))
		else $error("write response changed before acceptance");

	a_r_stable: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		bus_rvalid && !bus_rready |=> bus_rvalid && $stable(bus_rdata) && $stable(bus_rresp))
		else $error("read data changed before acceptance");

	// Registers settle after the first reset edge
	a_reset_quiet: assert property (@(posedge clk_50mhz)
		!resetn ##1 !resetn |-> !(bus_awvalid | bus_arvalid | bus_bvalid | bus_rvalid))
		else $error("valid high during reset");

endmodule

// ==== tests/soc_bus_tb.sv ====
// Testbench for the system bus, replaying a transaction list from both managers
`timescale 1ns/1ns

module soc_bus_tb import soc_bus_pkg::*; ();

	localparam int MAX_TESTS = 64;
	localparam int HOLD_CYCLES = 5;

	logic clk_50mhz = 1'b0;
	logic resetn;

	// Index 0 is the cpu port and index 1 the gfx port
	logic [1:0][31:0] awaddr, wdata, araddr;
	logic [1:0][3:0] wstrb;
	logic [1:0] awvalid, wvalid, bready, arvalid, rready;
	wire [1:0] awready, wready, bvalid, arready, rvalid;
	wire [1:0][1:0] bresp, rresp;
	wire [1:0][31:0] rdata;
	logic [7:0] palette_addr;
	colour_t palette_colour;

	string op_a [MAX_TESTS];
	int mgr_a [MAX_TESTS];
	int src_a [MAX_TESTS];
	addr_t addr_a [MAX_TESTS];
	data_t wdata_a [MAX_TESTS];
	strb_t strb_a [MAX_TESTS];
	data_t exp_a [MAX_TESTS];
	resp_t resp_a [MAX_TESTS];
	int n_tests = 0;
	logic loaded = 1'b0;
	int last_mgr = -1;
	int done_q [$];

	soc_bus_top i_dut (
		.clk_50mhz, .resetn,
		.cpu_awaddr(awaddr[0]), .cpu_awvalid(awvalid[0]), .cpu_awready(awready[0]),
		.cpu_wdata(wdata[0]), .cpu_wstrb(wstrb[0]), .cpu_wvalid(wvalid[0]),
		.cpu_wready(wready[0]),
		.cpu_bresp(bresp[0]), .cpu_bvalid(bvalid[0]), .cpu_bready(bready[0]),
		.cpu_araddr(araddr[0]), .cpu_arvalid(arvalid[0]), .cpu_arready(arready[0]),
		.cpu_rdata(rdata[0]), .cpu_rresp(rresp[0]), .cpu_rvalid(rvalid[0]),
		.cpu_rready(rready[0]),
		.gfx_awaddr(awaddr[1]), .gfx_awvalid(awvalid[1]), .gfx_awready(awready[1]),
		.gfx_wdata(wdata[1]), .gfx_wstrb(wstrb[1]), .gfx_wvalid(wvalid[1]),
		.gfx_wready(wready[1]),
		.gfx_bresp(bresp[1]), .gfx_bvalid(bvalid[1]), .gfx_bready(bready[1]),
		.gfx_araddr(araddr[1]), .gfx_arvalid(arvalid[1]), .gfx_arready(arready[1]),
		.gfx_rdata(rdata[1]), .gfx_rresp(rresp[1]), .gfx_rvalid(rvalid[1]),
		.gfx_rready(rready[1]),
		.palette_addr, .palette_colour
	);

	bind bus_arbiter soc_bus_props i_props (.*);

	always #10 clk_50mhz = ~clk_50mhz;

	task automatic stop_run(input string why);
		$display("Error: %s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic load_tests();
		int fd;
		int n;
		int lineno;
		int m;
		string line;
		string op;
		logic [31:0] a, d, s, e, r;
		fd = $fopen("tests/soc_bus_tests.txt", "r");
		if (fd == 0)
			stop_run("cannot open tests/soc_bus_tests.txt");
		lineno = 0;
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			lineno++;
			if (line.len() == 0 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %d %h %h %h %h %h", op, m, a, d, s, e, r);
			if (n <= 0)
				continue;
			if (n != 7 || n_tests == MAX_TESTS)
				stop_run($sformatf("test file line %0d cannot be used", lineno));
			op_a[n_tests] = op;
			mgr_a[n_tests] = m;
			src_a[n_tests] = lineno;
			addr_a[n_tests] = a;
			wdata_a[n_tests] = d;
			strb_a[n_tests] = s[3:0];
			exp_a[n_tests] = e;
			resp_a[n_tests] = r[1:0];
			n_tests++;
		end
		$fclose(fd);
	endtask

	// Entered and left 2 ns after a rising edge
	task automatic write_txn(input int m, input addr_t a, input data_t d, input strb_t s,
			output resp_t r);
		awaddr[m] = a;
		wdata[m] = d;
		wstrb[m] = s;
		awvalid[m] = 1'b1;
		wvalid[m] = 1'b1;
		do @(negedge clk_50mhz); while (!(awready[m] && wready[m]));
		@(posedge clk_50mhz);
		#2;
		awvalid[m] = 1'b0;
		wvalid[m] = 1'b0;
		do @(negedge clk_50mhz); while (!bvalid[m]);
		r = bresp[m];
		done_q.push_back(m);
		// Response waits one cycle for bready
		@(posedge clk_50mhz);
		#2;
		bready[m] = 1'b1;
		@(negedge clk_50mhz);
		check(bvalid[m], 1'b1, "bvalid while bready was low");
		check(bresp[m], r, "bresp while bready was low");
		@(posedge clk_50mhz);
		#2;
		bready[m] = 1'b0;
	endtask

	task automatic read_txn(input int m, input addr_t a, input int hold, output data_t d,
			output resp_t r);
		araddr[m] = a;
		arvalid[m] = 1'b1;
		rready[m] = (hold == 0);
		do @(negedge clk_50mhz); while (!arready[m]);
		@(posedge clk_50mhz);
		#2;
		arvalid[m] = 1'b0;
		do @(negedge clk_50mhz); while (!rvalid[m]);
		d = rdata[m];
		r = rresp[m];
		done_q.push_back(m);
		if (hold > 0) begin
			// Response frozen while the other manager stays locked out
			repeat (hold) begin
				@(negedge clk_50mhz);
				check(rvalid[m], 1'b1, "rvalid under back-pressure");
				check(rdata[m], d, "rdata under back-pressure");
				check(rresp[m], r, "rresp under back-pressure");
				check(arready[1 - m], 1'b0, "other manager arready under back-pressure");
			end
			@(posedge clk_50mhz);
			#2;
			rready[m] = 1'b1;
		end
		@(posedge clk_50mhz);
		#2;
		rready[m] = 1'b0;
	endtask

	task automatic run_single(input int i);
		data_t d;
		resp_t r;
		if (op_a[i] == "w" || op_a[i] == "pw") begin
			write_txn(mgr_a[i], addr_a[i], wdata_a[i], strb_a[i], r);
			check(r, resp_a[i], $sformatf("line %0d bresp", src_a[i]));
		end else begin
			read_txn(mgr_a[i], addr_a[i], 0, d, r);
			check(d, exp_a[i], $sformatf("line %0d rdata", src_a[i]));
			check(r, resp_a[i], $sformatf("line %0d rresp", src_a[i]));
		end
	endtask

	initial begin
		#(1);
		wait (loaded);
		#(n_tests * 50 * 20);
		$display("Timeout: %0d test lines did not finish in time", n_tests);
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		int i;
		int m;
		data_t d1, d2;
		resp_t r1, r2;
		resetn = 1'b0;
		awaddr = '0;
		wdata = '0;
		wstrb = '0;
		araddr = '0;
		awvalid = '0;
		wvalid = '0;
		bready = '0;
		arvalid = '0;
		rready = '0;
		palette_addr = '0;
		load_tests();
		loaded = 1'b1;
		repeat (3) @(posedge clk_50mhz);
		#2;
		resetn = 1'b1;
		@(posedge clk_50mhz);
		#2;
		i = 0;
		while (i < n_tests) begin
			m = mgr_a[i];
			if (op_a[i] == "w" || op_a[i] == "r") begin
				run_single(i);
				last_mgr = m;
				i++;
			end else if (op_a[i] == "c") begin
				read_txn(m, addr_a[i], 0, d1, r1);
				read_txn(m, addr_a[i], 0, d2, r2);
				check(r1, resp_a[i], $sformatf("line %0d first counter rresp", src_a[i]));
				check(r2, resp_a[i], $sformatf("line %0d second counter rresp", src_a[i]));
				check(d2 > d1, 1'b1, $sformatf("line %0d counter increasing", src_a[i]));
				last_mgr = m;
				i++;
			end else if (op_a[i] == "l") begin
				palette_addr = addr_a[i][7:0];
				@(posedge clk_50mhz);
				@(negedge clk_50mhz);
				check(palette_colour, exp_a[i], $sformatf("line %0d palette_colour", src_a[i]));
				@(posedge clk_50mhz);
				#2;
				i++;
			end else if (op_a[i] == "b") begin
				// Second reader arrives once the first holds the grant
				fork
					read_txn(m, addr_a[i], HOLD_CYCLES, d1, r1);
					begin
						@(posedge clk_50mhz);
						#2;
						read_txn(1 - m, addr_a[i], 0, d2, r2);
					end
				join
				check(d1, exp_a[i], $sformatf("line %0d held rdata", src_a[i]));
				check(r1, resp_a[i], $sformatf("line %0d held rresp", src_a[i]));
				check(d2, exp_a[i], $sformatf("line %0d waiting rdata", src_a[i]));
				check(r2, resp_a[i], $sformatf("line %0d waiting rresp", src_a[i]));
				last_mgr = 1 - m;
				i++;
			end else if (op_a[i] == "pw" || op_a[i] == "pr") begin
				if (i + 1 >= n_tests || (op_a[i + 1] != "pw" && op_a[i + 1] != "pr")
						|| mgr_a[i + 1] == m)
					stop_run($sformatf("paired line %0d has no partner", src_a[i]));
				done_q.delete();
				fork
					run_single(i);
					run_single(i + 1);
				join
				// Tie goes to the manager without the last grant
				if (last_mgr >= 0)
					check(done_q[0], 1 - last_mgr,
						$sformatf("line %0d first manager to finish", src_a[i]));
				last_mgr = done_q[1];
				i += 2;
			end else begin
				stop_run($sformatf("unknown operation on test file line %0d", src_a[i]));
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== soc_bus.f ====
source/soc_bus_pkg.sv
source/system_counter.sv
source/axil_ram.sv
source/addr_decoder.sv
source/bus_arbiter.sv
source/soc_bus_top.sv
tests/soc_bus_props.sv
tests/soc_bus_tb.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - source/soc_bus_pkg.sv
  - source/system_counter.sv
  - source/axil_ram.sv
  - source/addr_decoder.sv
  - source/bus_arbiter.sv
  - source/soc_bus_top.sv
  - target: test
    files:
      - tests/soc_bus_props.sv
      - tests/soc_bus_tb.sv

// ==== tests/soc_bus_tests.txt ====
# op mgr addr wdata strb exp_data exp_resp  (mgr decimal 0 cpu 1 gfx, the rest hex)
# op: w write, r read, c two counter reads, l palette lookup, b held read, pw/pr paired
w  0 02010000 11223344 f 00000000 0
w  1 02010004 a5a5a5a5 f 00000000 0
w  0 02010004 0000cc00 2 00000000 0
w  1 02010000 ffee0000 c 00000000 0
r  1 02010004 00000000 0 a5a5cca5 0
r  0 02010000 00000000 0 ffee3344 0
w  0 02002014 deadbeef f 00000000 0
r  1 02002014 00000000 0 0000beef 0
w  1 02002014 12345678 c 00000000 0
r  0 02002014 00000000 0 0000beef 0
w  0 02002014 00007700 2 00000000 0
r  1 02002014 00000000 0 000077ef 0
l  0 00000005 00000000 0 000077ef 0
w  1 03000000 12345678 f 00000000 3
r  0 03000000 00000000 0 00000000 3
r  1 02008000 00000000 0 00000000 3
w  0 02000300 00000001 f 00000000 2
c  1 02000300 00000000 0 00000000 0
w  0 02010010 aaaa0001 f 00000000 0
pw 0 02010020 01010101 f 00000000 0
pw 1 02010024 02020202 f 00000000 0
r  1 02010010 00000000 0 aaaa0001 0
pr 0 02010020 00000000 0 01010101 0
pr 1 02010024 00000000 0 02020202 0
r  0 02010024 00000000 0 02020202 0
pr 1 02010004 00000000 0 a5a5cca5 0
pr 0 02010000 00000000 0 ffee3344 0
b  0 02010020 00000000 0 01010101 0
b  1 02002014 00000000 0 000077ef 0
w  1 02010ffc 0badf00d f 00000000 0
r  0 02010ffc 00000000 0 0badf00d 0
